//--- Makefile
SIM = obj_dir/Vtb_led_matrix

.PHONY: all lint clean

all: $(SIM)
	./$(SIM) | tee sim.log
	grep -q -F "*** TEST PASSED ***" sim.log

$(SIM): files.f $(wildcard hw/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert --top-module tb_led_matrix -f files.f

lint:
	verilator --lint-only --timing -Wall --top-module led_matrix_top -f files.f

clean:
	rm -rf obj_dir sim.log

//--- files.f
hw/led_matrix_pkg.sv
hw/uart_rx.sv
hw/control_module.sv
hw/framebuffer.sv
hw/framebuffer_fetch.sv
hw/pixel_split.sv
hw/matrix_scan.sv
hw/led_matrix_top.sv
tb/matrix_checker.sv
tb/tb_led_matrix.sv

//--- hw/control_module.sv
`timescale 1ns/1ps
`default_nettype none

module control_module import led_matrix_pkg::*; (
    input  logic                 clk_in,
    input  logic                 rst_n,
    input  logic [7:0]           rx_data,
    input  logic                 rx_valid,
    output logic [FB_ADDR_W-1:0] ram_addr,
    output logic [7:0]           ram_wdata,
    output logic                 ram_we,
    output logic [2:0]           rgb_enable,         // Bit 0 red, 1 green, 2 blue
    output logic [5:0]           brightness_enable   // One bit per plane
);

    typedef enum logic [1:0] {CTL_IDLE, CTL_LOAD, CTL_RGB_ARG, CTL_BRIGHT_ARG} ctl_state_t;

    ctl_state_t state;
    logic [FB_ADDR_W-1:0] byte_cnt;

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state             <= CTL_IDLE;
            byte_cnt          <= '0;
            ram_we            <= 1'b0;
            rgb_enable        <= '1;
            brightness_enable <= '1;
        end else begin
            ram_we <= 1'b0;
            if (rx_valid) begin
                case (state)
                    CTL_IDLE: begin
                        case (rx_data)
                            CMD_LOAD: begin
                                state    <= CTL_LOAD;
                                byte_cnt <= '0;
                            end
                            CMD_RGB_EN:    state <= CTL_RGB_ARG;
                            CMD_BRIGHT_EN: state <= CTL_BRIGHT_ARG;
                            default:       state <= CTL_IDLE;  // Stray byte
                        endcase
                    end
                    CTL_LOAD: begin
                        ram_we   <= 1'b1;
                        byte_cnt <= byte_cnt + 1'b1;
                        if (byte_cnt == FB_ADDR_W'(FB_BYTES - 1)) begin
                            state <= CTL_IDLE;  // Frame complete
                        end
                    end
                    CTL_RGB_ARG: begin
                        rgb_enable <= rx_data[2:0];
                        state      <= CTL_IDLE;
                    end
                    CTL_BRIGHT_ARG: begin
                        brightness_enable <= rx_data[5:0];
                        state             <= CTL_IDLE;
                    end
                    default: state <= CTL_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rx_valid && state == CTL_LOAD) begin
            ram_addr  <= byte_cnt;
            ram_wdata <= rx_data;
        end
    end

    a_we_from_load: assert property (@(posedge clk_in) disable iff (!rst_n)
        ram_we |-> $past(state == CTL_LOAD));

endmodule

`default_nettype wire

//--- hw/framebuffer.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer import led_matrix_pkg::*; (
    input  logic                     clk_in,
    input  logic [FB_ADDR_W-1:0]     wr_addr,
    input  logic [7:0]               wr_data,
    input  logic                     wr_en,
    input  logic [FB_PIX_ADDR_W-1:0] rd_addr,
    output logic [15:0]              rd_data
);

    // One lane per byte of a pixel
    logic [7:0] mem_hi [FB_BYTES / BYTES_PER_PIXEL];
    logic [7:0] mem_lo [FB_BYTES / BYTES_PER_PIXEL];

    always_ff @(posedge clk_in) begin
        if (wr_en) begin
            if (wr_addr[0]) begin
                mem_lo[wr_addr[FB_ADDR_W-1:1]] <= wr_data;  // Odd address is low byte
            end else begin
                mem_hi[wr_addr[FB_ADDR_W-1:1]] <= wr_data;
            end
        end
    end

    // Single cycle read latency
    always_ff @(posedge clk_in) begin
        rd_data <= {mem_hi[rd_addr], mem_lo[rd_addr]};
    end

endmodule

`default_nettype wire

//--- hw/framebuffer_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module framebuffer_fetch import led_matrix_pkg::*; (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  logic [$clog2(PIXEL_WIDTH)-1:0]      column_address,
    input  logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address,
    input  logic                                pixel_load_start,
    output logic [FB_PIX_ADDR_W-1:0]            ram_address,
    input  logic [15:0]                         ram_data,
    output logic [15:0]                         rgb565_top,
    output logic [15:0]                         rgb565_bottom
);

    logic [1:0] step;
    logic [FB_PIX_ADDR_W-2:0] pix_index;  // Row and column inside a half

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            step <= '0;
        end else if (step == 2'd0) begin
            if (pixel_load_start) begin
                step <= 2'd1;
            end
        end else begin
            step <= step + 1'b1;  // Wraps back to idle after capture
        end
    end

    // Top bit of the pixel address selects the bottom half, row + 4
    always_ff @(posedge clk_in) begin
        case (step)
            2'd0: begin
                if (pixel_load_start) begin
                    pix_index   <= {row_address, column_address};
                    ram_address <= {1'b0, row_address, column_address};
                end
            end
            2'd1: ram_address <= {1'b1, pix_index};
            2'd2: rgb565_top <= ram_data;      // Top read lands
            default: rgb565_bottom <= ram_data;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/led_matrix_pkg.sv
`default_nettype none

package led_matrix_pkg;

    // Panel geometry, scanned as two halves
    localparam int PIXEL_WIDTH      = 16;
    localparam int PIXEL_HALFHEIGHT = 4;
    localparam int PIXEL_HEIGHT     = 8;
    localparam int NUM_HALVES       = 2;

    // Framebuffer layout, RGB565 stored high byte first
    localparam int BYTES_PER_PIXEL = 2;
    localparam int FB_BYTES        = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;
    localparam int FB_ADDR_W       = 8;   // Byte address
    localparam int FB_PIX_ADDR_W   = 7;   // Pixel address

    // Binary coded modulation
    localparam int NUM_PLANES = 6;
    localparam int PLANE_W    = 3;
    localparam int PIXEL_DIV  = 4;        // clk_in cycles per pixel clock
    localparam int OE_BASE    = 8;        // Plane 0 on-time in clk_in cycles
    localparam int OE_CNT_W   = $clog2(OE_BASE << NUM_PLANES);

    localparam int UART_TICKS_PER_BIT = 8;

    // Command bytes
    localparam logic [7:0] CMD_LOAD      = 8'h4C;  // L
    localparam logic [7:0] CMD_RGB_EN    = 8'h45;  // E
    localparam logic [7:0] CMD_BRIGHT_EN = 8'h42;  // B

endpackage

`default_nettype wire

//--- hw/led_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module led_matrix_top import led_matrix_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       uart_rx,
    output logic       clk_pixel,
    output logic       row_latch,
    output logic       output_enable,
    output logic [1:0] row_addr,
    output logic [2:0] rgb1,
    output logic [2:0] rgb2
);

    logic [7:0] rx_data;
    logic rx_valid;
    logic [FB_ADDR_W-1:0] ram_addr;
    logic [7:0] ram_wdata;
    logic ram_we;
    logic [2:0] rgb_enable;
    logic [5:0] brightness_enable;
    logic [FB_PIX_ADDR_W-1:0] fetch_addr;
    logic [15:0] fetch_data;
    logic [$clog2(PIXEL_WIDTH)-1:0] column_address;
    logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address;
    logic [PLANE_W-1:0] plane;
    logic pixel_load_start;
    logic [15:0] half_pixel [NUM_HALVES];  // Index 0 top, 1 bottom
    logic [2:0] half_rgb [NUM_HALVES];

    uart_rx uart_rx_inst (
        .clk_in   (clk_in),
        .rst_n    (rst_n),
        .rx       (uart_rx),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    control_module control_module_inst (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid),
        .ram_addr          (ram_addr),
        .ram_wdata         (ram_wdata),
        .ram_we            (ram_we),
        .rgb_enable        (rgb_enable),
        .brightness_enable (brightness_enable)
    );

    framebuffer framebuffer_inst (
        .clk_in  (clk_in),
        .wr_addr (ram_addr),
        .wr_data (ram_wdata),
        .wr_en   (ram_we),
        .rd_addr (fetch_addr),
        .rd_data (fetch_data)
    );

    framebuffer_fetch framebuffer_fetch_inst (
        .clk_in           (clk_in),
        .rst_n            (rst_n),
        .column_address   (column_address),
        .row_address      (row_address),
        .pixel_load_start (pixel_load_start),
        .ram_address      (fetch_addr),
        .ram_data         (fetch_data),
        .rgb565_top       (half_pixel[0]),
        .rgb565_bottom    (half_pixel[1])
    );

    for (genvar h = 0; h < NUM_HALVES; h++) begin : g_half
        pixel_split pixel_split_inst (
            .pixel_rgb565      (half_pixel[h]),
            .plane             (plane),
            .brightness_enable (brightness_enable),
            .rgb_enable        (rgb_enable),
            .rgb_output        (half_rgb[h])
        );
    end

    matrix_scan matrix_scan_inst (
        .clk_in           (clk_in),
        .rst_n            (rst_n),
        .rgb_top          (half_rgb[0]),
        .rgb_bottom       (half_rgb[1]),
        .column_address   (column_address),
        .row_address      (row_address),
        .plane            (plane),
        .pixel_load_start (pixel_load_start),
        .clk_pixel        (clk_pixel),
        .rgb1             (rgb1),
        .rgb2             (rgb2),
        .row_latch        (row_latch),
        .output_enable    (output_enable),
        .row_addr         (row_addr)
    );

endmodule

`default_nettype wire

//--- hw/matrix_scan.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_scan import led_matrix_pkg::*; (
    input  logic                                clk_in,
    input  logic                                rst_n,
    input  logic [2:0]                          rgb_top,
    input  logic [2:0]                          rgb_bottom,
    output logic [$clog2(PIXEL_WIDTH)-1:0]      column_address,
    output logic [$clog2(PIXEL_HALFHEIGHT)-1:0] row_address,
    output logic [PLANE_W-1:0]                  plane,
    output logic                                pixel_load_start,
    output logic                                clk_pixel,
    output logic [2:0]                          rgb1,
    output logic [2:0]                          rgb2,
    output logic                                row_latch,
    output logic                                output_enable,
    output logic [1:0]                          row_addr
);

    typedef enum logic [2:0] {ST_FETCH, ST_SHIFT, ST_LATCH, ST_OE, ST_IDLE} scan_state_t;

    scan_state_t state;
    logic [$clog2(PIXEL_DIV)-1:0] div_cnt;
    logic [$clog2(PIXEL_WIDTH)-1:0] shift_cnt;
    logic [OE_CNT_W-1:0] oe_cnt;
    logic period_end;

    assign period_end = (div_cnt == PIXEL_DIV - 1);

    // Fetch runs one column ahead of the shift register
    assign column_address = (state == ST_SHIFT) ? shift_cnt + 1'b1 : '0;

    always_comb begin
        case (state)
            ST_FETCH: pixel_load_start = (div_cnt == '0);
            ST_SHIFT: pixel_load_start = (div_cnt == '0) && (shift_cnt != PIXEL_WIDTH - 1);
            ST_LATCH: pixel_load_start = 1'b1;  // Column 0 of the next plane
            default:  pixel_load_start = 1'b0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state         <= ST_FETCH;
            div_cnt       <= '0;
            shift_cnt     <= '0;
            oe_cnt        <= '0;
            row_address   <= '0;
            plane         <= '0;
            row_addr      <= '0;
            clk_pixel     <= 1'b0;
            row_latch     <= 1'b0;
            output_enable <= 1'b0;
            rgb1          <= '0;
            rgb2          <= '0;
        end else begin
            case (state)
                ST_FETCH: begin
                    div_cnt <= div_cnt + 1'b1;
                    if (period_end) begin
                        state <= ST_SHIFT;
                    end
                end
                ST_SHIFT: begin
                    div_cnt   <= div_cnt + 1'b1;
                    clk_pixel <= (div_cnt >= PIXEL_DIV / 2 - 1) && !period_end;
                    if (div_cnt == '0) begin
                        rgb1 <= rgb_top;     // Low phase of clk_pixel
                        rgb2 <= rgb_bottom;
                    end
                    if (period_end) begin
                        shift_cnt <= shift_cnt + 1'b1;
                        if (shift_cnt == PIXEL_WIDTH - 1) begin
                            state     <= ST_LATCH;
                            row_latch <= 1'b1;
                            row_addr  <= row_address;
                            oe_cnt    <= OE_CNT_W'((OE_BASE << plane) - 1);
                            if (plane == NUM_PLANES - 1) begin
                                plane       <= '0;
                                row_address <= (row_address == PIXEL_HALFHEIGHT - 1) ?
                                               '0 : row_address + 1'b1;
                            end else begin
                                plane <= plane + 1'b1;
                            end
                        end
                    end
                end
                ST_LATCH: begin
                    row_latch     <= 1'b0;
                    output_enable <= 1'b1;
                    state         <= ST_OE;
                end
                ST_OE: begin
                    if (oe_cnt == '0) begin
                        output_enable <= 1'b0;
                        state         <= ST_IDLE;
                    end else begin
                        oe_cnt <= oe_cnt - 1'b1;
                    end
                end
                ST_IDLE: state <= ST_SHIFT;
                default: state <= ST_FETCH;
            endcase
        end
    end

    a_oe_vs_latch: assert property (@(posedge clk_in) disable iff (!rst_n)
        !(output_enable && row_latch));

endmodule

`default_nettype wire

//--- hw/pixel_split.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_split import led_matrix_pkg::*; (
    input  logic [15:0]        pixel_rgb565,
    input  logic [PLANE_W-1:0] plane,
    input  logic [5:0]         brightness_enable,
    input  logic [2:0]         rgb_enable,
    output logic [2:0]         rgb_output   // Bit 0 red, 1 green, 2 blue
);

    logic [4:0] red;
    logic [5:0] green;
    logic [4:0] blue;
    logic [PLANE_W-1:0] rb_index;
    logic plane_on;

    assign {red, green, blue} = pixel_rgb565;

    // Red and blue are one bit short, so they sit one plane behind green
    assign rb_index = plane - 1'b1;
    assign plane_on = (plane < NUM_PLANES) && brightness_enable[plane];

    assign rgb_output[0] = plane_on && rgb_enable[0] && (plane != '0) && red[rb_index];
    assign rgb_output[1] = plane_on && rgb_enable[1] && green[plane];
    assign rgb_output[2] = plane_on && rgb_enable[2] && (plane != '0) && blue[rb_index];

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx import led_matrix_pkg::*; (
    input  logic       clk_in,
    input  logic       rst_n,
    input  logic       rx,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

    rx_state_t state;
    logic [1:0] rx_sync;
    logic [$clog2(UART_TICKS_PER_BIT)-1:0] tick_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shift_reg;
    logic bit_mid;
    logic start_mid;

    assign bit_mid   = (tick_cnt == UART_TICKS_PER_BIT - 1);
    assign start_mid = (tick_cnt == UART_TICKS_PER_BIT / 2 - 1);  // Half a bit after the edge

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            rx_sync <= 2'b11;  // Line idles high
        end else begin
            rx_sync <= {rx_sync[0], rx};
        end
    end

    always_ff @(posedge clk_in) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!rx_sync[1]) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    if (start_mid) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync[1] ? RX_IDLE : RX_DATA;  // Glitch, not a start bit
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (bit_mid) begin
                        state    <= RX_IDLE;
                        rx_valid <= rx_sync[1];  // Framing error drops the byte
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk_in) begin
        if (state == RX_DATA && bit_mid) begin
            shift_reg <= {rx_sync[1], shift_reg[7:1]};
        end
        if (state == RX_STOP && bit_mid) begin
            rx_data <= shift_reg;
        end
    end

    a_single_strobe: assert property (@(posedge clk_in) disable iff (!rst_n)
        rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

//--- tb/matrix_checker.sv
`timescale 1ns/1ps
`default_nettype none

module matrix_checker import led_matrix_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_n,
    input  logic        clk_pixel,
    input  logic        row_latch,
    input  logic        output_enable,
    input  logic [1:0]  row_addr,
    input  logic [2:0]  rgb1,
    input  logic [2:0]  rgb2,
    input  logic        check_arm,
    input  logic [15:0] frame [PIXEL_WIDTH * PIXEL_HEIGHT],
    input  logic [2:0]  rgb_enable,
    input  logic [5:0]  brightness_enable,
    output logic        check_done,
    output int          error_count
);

    logic [2:0] top_cols [PIXEL_WIDTH];  // Columns shifted in the current period
    logic [2:0] bot_cols [PIXEL_WIDTH];
    logic [1:0] lat_row;                 // Row and plane of the last latch
    logic [2:0] lat_plane;
    logic clk_pixel_q;
    logic output_enable_q;
    logic rst_n_q;
    logic arm_q;
    logic startup;
    logic waiting;
    logic checking;
    int latch_count;
    int rise_count;
    int oe_count;
    int periods_left;

    task automatic fail_check(input string msg);
        error_count = error_count + 1;
        $display("FAIL at %0t: %s", $time, msg);
    endtask

    // Green gives bit p, red and blue give bit p-1 and nothing on plane 0
    function automatic logic [2:0] expected_bits(input logic [15:0] pix,
                                                 input logic [2:0] plane,
                                                 input logic [2:0] en,
                                                 input logic [5:0] planes);
        logic [2:0] bits;
        bits[0] = (plane == 3'd0) ? 1'b0 : pix[4'(10 + plane)];
        bits[1] = pix[4'(5 + plane)];
        bits[2] = (plane == 3'd0) ? 1'b0 : pix[4'(plane - 1)];
        return planes[plane] ? (bits & en) : 3'b000;
    endfunction

    task automatic compare_period(input logic [1:0] row, input logic [2:0] plane);
        logic [6:0] top_idx;
        logic [6:0] bot_idx;
        logic [2:0] exp_top;
        logic [2:0] exp_bot;
        for (int c = 0; c < PIXEL_WIDTH; c++) begin
            top_idx = 7'(row * PIXEL_WIDTH + c);
            bot_idx = 7'((row + PIXEL_HALFHEIGHT) * PIXEL_WIDTH + c);
            exp_top = expected_bits(frame[top_idx], plane, rgb_enable, brightness_enable);
            exp_bot = expected_bits(frame[bot_idx], plane, rgb_enable, brightness_enable);
            if (top_cols[c[3:0]] !== exp_top) begin
                fail_check($sformatf("row %0d plane %0d column %0d rgb1 %b, expected %b",
                                     row, plane, c, top_cols[c[3:0]], exp_top));
            end
            if (bot_cols[c[3:0]] !== exp_bot) begin
                fail_check($sformatf("row %0d plane %0d column %0d rgb2 %b, expected %b",
                                     row + PIXEL_HALFHEIGHT, plane, c, bot_cols[c[3:0]], exp_bot));
            end
        end
    endtask

    always @(posedge clk_in) begin
        check_done <= 1'b0;
        if (!rst_n) begin
            error_count     = 0;
            latch_count     = 0;
            rise_count      = 0;
            oe_count        = 0;
            periods_left    = 0;
            lat_row         = 2'd0;
            lat_plane       = 3'd0;
            startup         = 1'b1;
            waiting         = 1'b0;
            checking        = 1'b0;
            clk_pixel_q     = 1'b0;
            output_enable_q = 1'b0;
            arm_q           = 1'b0;
            rst_n_q         = 1'b0;
        end else begin
            if (startup) begin
                if (clk_pixel === 1'b1 && rst_n_q) begin
                    startup = 1'b0;  // First pixel period under way
                end else if (clk_pixel !== 1'b0 || row_latch !== 1'b0 ||
                             output_enable !== 1'b0) begin
                    fail_check("panel controls active before the first pixel period");
                end
            end
            if (output_enable && (row_latch || clk_pixel)) begin
                fail_check("output enable overlaps the latch or the pixel clock");
            end
            if (clk_pixel && !clk_pixel_q) begin
                if (rise_count < PIXEL_WIDTH) begin
                    top_cols[rise_count[3:0]] = rgb1;
                    bot_cols[rise_count[3:0]] = rgb2;
                end
                rise_count = rise_count + 1;
            end
            if (output_enable) begin
                oe_count = oe_count + 1;
                if (row_addr !== lat_row) begin
                    fail_check($sformatf("row_addr %0d during on-time, expected %0d",
                                         row_addr, lat_row));
                end
            end else if (output_enable_q) begin
                if (oe_count != (OE_BASE << lat_plane)) begin
                    fail_check($sformatf("plane %0d on-time %0d cycles, expected %0d",
                                         lat_plane, oe_count, OE_BASE << lat_plane));
                end
                oe_count = 0;
            end
            if (check_arm && !arm_q) begin
                waiting = 1'b1;  // Start at the next period boundary
            end
            if (row_latch) begin
                lat_plane = 3'(latch_count % NUM_PLANES);
                lat_row   = 2'((latch_count / NUM_PLANES) % PIXEL_HALFHEIGHT);
                if (rise_count != PIXEL_WIDTH) begin
                    fail_check($sformatf("%0d pixel clock edges before latch, expected %0d",
                                         rise_count, PIXEL_WIDTH));
                end
                if (checking) begin
                    compare_period(lat_row, lat_plane);
                    periods_left = periods_left - 1;
                    if (periods_left == 0) begin
                        checking = 1'b0;
                        check_done <= 1'b1;
                    end
                end else if (waiting) begin
                    waiting      = 1'b0;
                    checking     = 1'b1;
                    periods_left = PIXEL_HALFHEIGHT * NUM_PLANES;
                end
                latch_count = latch_count + 1;
                rise_count  = 0;
            end
            clk_pixel_q     = clk_pixel;
            output_enable_q = output_enable;
            arm_q           = check_arm;
            rst_n_q         = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_led_matrix.sv
`timescale 1ns/1ps
`default_nettype none

module tb_led_matrix import led_matrix_pkg::*; ();

    localparam int NUM_ENTRIES = 4;
    localparam int NUM_PIXELS  = PIXEL_WIDTH * PIXEL_HEIGHT;
    localparam int BYTE_CYCLES = 10 * UART_TICKS_PER_BIT;  // Start, 8 data, stop
    localparam int ENTRY_BYTES = 262;                      // Commands, frame and gaps
    localparam int SCAN_CYCLES = 3700;                     // 4 rows of 6 planes
    localparam int TIMEOUT_CYCLES =
        NUM_ENTRIES * (ENTRY_BYTES * BYTE_CYCLES + 2 * SCAN_CYCLES) * 4 / 3;

    typedef struct packed {
        logic       random_frame;
        logic [2:0] rgb_en;
        logic [5:0] bright_en;
    } entry_t;

    entry_t test_table [NUM_ENTRIES] = '{
        '{random_frame: 1'b1, rgb_en: 3'b111, bright_en: 6'b111111},
        '{random_frame: 1'b0, rgb_en: 3'b001, bright_en: 6'b111111},  // Red only
        '{random_frame: 1'b1, rgb_en: 3'b111, bright_en: 6'b100101},  // Planes 0, 2, 5
        '{random_frame: 1'b0, rgb_en: 3'b110, bright_en: 6'b011110}   // Green and blue
    };

    logic clk_in;
    logic rst_n;
    logic uart_rx;
    logic clk_pixel;
    logic row_latch;
    logic output_enable;
    logic [1:0] row_addr;
    logic [2:0] rgb1;
    logic [2:0] rgb2;
    logic [15:0] frame_pixels [NUM_PIXELS];
    logic [2:0] exp_rgb_enable;
    logic [5:0] exp_brightness_enable;
    logic check_arm;
    logic check_done;
    int error_count;
    int cycle_count;
    logic [31:0] rng_state;

    led_matrix_top led_matrix_top_inst (
        .clk_in        (clk_in),
        .rst_n         (rst_n),
        .uart_rx       (uart_rx),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable),
        .row_addr      (row_addr),
        .rgb1          (rgb1),
        .rgb2          (rgb2)
    );

    matrix_checker matrix_checker_inst (
        .clk_in            (clk_in),
        .rst_n             (rst_n),
        .clk_pixel         (clk_pixel),
        .row_latch         (row_latch),
        .output_enable     (output_enable),
        .row_addr          (row_addr),
        .rgb1              (rgb1),
        .rgb2              (rgb2),
        .check_arm         (check_arm),
        .frame             (frame_pixels),
        .rgb_enable        (exp_rgb_enable),
        .brightness_enable (exp_brightness_enable),
        .check_done        (check_done),
        .error_count       (error_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // 8N1, LSB first
    task automatic send_byte(input logic [7:0] value);
        logic [9:0] bits;
        bits = {1'b1, value, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx <= bits[i[3:0]];
            repeat (UART_TICKS_PER_BIT) @(posedge clk_in);
        end
    endtask

    task automatic fill_frame(input logic random_frame);
        for (int i = 0; i < NUM_PIXELS; i++) begin
            if (random_frame) begin
                rng_state = xorshift32(rng_state);
                frame_pixels[i[6:0]] = rng_state[15:0];
            end else begin
                frame_pixels[i[6:0]] = 16'(i * 613) ^ 16'hA55A;  // Whole index matters
            end
        end
    endtask

    initial begin
        clk_in = 1'b0;
        forever #4 clk_in = ~clk_in;
    end

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_in);
            cycle_count = cycle_count + 1;
        end
        $display("Timeout: scan checks still running after %0d cycles", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        rst_n                 = 1'b0;
        uart_rx               = 1'b1;  // Idle line
        check_arm             = 1'b0;
        exp_rgb_enable        = 3'b111;
        exp_brightness_enable = 6'b111111;
        rng_state             = 32'h952b_5fd3;
        repeat (2) @(posedge clk_in);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk_in);
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            fill_frame(test_table[e[1:0]].random_frame);
            send_byte(CMD_RGB_EN);
            send_byte({5'b0, test_table[e[1:0]].rgb_en});
            send_byte(CMD_BRIGHT_EN);
            send_byte({2'b0, test_table[e[1:0]].bright_en});
            send_byte(CMD_LOAD);
            for (int i = 0; i < NUM_PIXELS; i++) begin
                send_byte(frame_pixels[i[6:0]][15:8]);  // High byte first
                send_byte(frame_pixels[i[6:0]][7:0]);
            end
            repeat (BYTE_CYCLES) @(posedge clk_in);
            exp_rgb_enable        <= test_table[e[1:0]].rgb_en;
            exp_brightness_enable <= test_table[e[1:0]].bright_en;
            check_arm             <= 1'b1;
            @(posedge clk_in);
            while (!check_done) begin
                @(posedge clk_in);
            end
            check_arm <= 1'b0;
        end
        @(negedge clk_in);
        $display("Scan checks complete, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
